// ==== hdl/core_pkg.sv ====
// Widths, op encodings, CSR map and packet structs shared by the writeback RTL and its testbench
package core_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int XLEN       = 64;   // Data width
    localparam int REG_ADDR_W = 5;    // 32 GPRs
    localparam int CSR_ADDR_W = 12;
    localparam int CAUSE_W    = 6;

    // Machine mode CSR subset
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL    = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET = 12'hB02;

    localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL    = 6'd2;
    localparam logic [CAUSE_W-1:0] CAUSE_LOAD_FAULT = 6'd5;

    // ------------------------------------------------------------------------
    // Operation encodings
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic load;      // Load instruction
        logic is_byte;
        logic is_half;
        logic is_word;   // None of the three means doubleword
        logic sext;      // Sign extend result
    } lsu_op_t;

    typedef struct packed {
        logic rd;
        logic wr;
        logic set;
        logic clr;
    } csr_op_t;          // One hot for CSR instructions

    typedef enum logic [1:0] {
        WB_NONE  = 2'd0,
        WB_WDATA = 2'd1,
        WB_LSU   = 2'd2,
        WB_CSR   = 2'd3
    } wb_op_t;

    // ------------------------------------------------------------------------
    // Packets
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       n_pc;
        logic [31:0]           instr;
        logic [XLEN-1:0]       wdata;      // ALU result, load address or CSR operand
        logic [REG_ADDR_W-1:0] rd;
        lsu_op_t               lsu_op;
        csr_op_t               csr_op;
        logic [CSR_ADDR_W-1:0] csr_addr;
        wb_op_t                wb_op;
        logic                  trap;       // Trap raised upstream
        logic [CAUSE_W-1:0]    cause;
    } wb_instr_t;

    typedef struct packed {
        logic                  wen;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       wdata;
    } rd_write_t;

    typedef struct packed {
        logic                  en;
        csr_op_t               op;
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       wdata;
    } csr_req_t;

    typedef struct packed {
        logic [XLEN-1:0] rdata;
        logic            error;   // Unknown CSR or write to read only
    } csr_rsp_t;

    typedef struct packed {
        logic               valid;
        logic [CAUSE_W-1:0] cause;
        logic [XLEN-1:0]    mtval;
        logic [XLEN-1:0]    pc;
    } trap_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
        logic            trap;
    } trace_t;

endpackage

// ==== hdl/core_load_align.sv ====
// Load data aligner used by writeback to shift the 64-bit read word to its lane and size it
`timescale 1ns/1ps

module core_load_align
    import core_pkg::*;
(
    input  lsu_op_t         lsu_op,       // Size and sign flags
    input  logic [2:0]      offset,       // Byte offset in the doubleword
    input  logic [XLEN-1:0] dmem_rdata,   // Raw bus data
    output logic [XLEN-1:0] rdata         // GPR ready value
);

    logic [XLEN-1:0] shifted;
    logic [XLEN-1:0] rdata_byte;
    logic [XLEN-1:0] rdata_half;
    logic [XLEN-1:0] rdata_word;
    logic            sign_byte;
    logic            sign_half;
    logic            sign_word;

    // ------------------------------------------------------------------------
    // Lane select and sizing
    // ------------------------------------------------------------------------
    assign shifted   = dmem_rdata >> {offset, 3'b000};     // 8 bits per byte of offset

    assign sign_byte = lsu_op.sext && shifted[7];
    assign sign_half = lsu_op.sext && shifted[15];
    assign sign_word = lsu_op.sext && shifted[31];

    assign rdata_byte = {{(XLEN-8){sign_byte}}, shifted[7:0]};
    assign rdata_half = {{(XLEN-16){sign_half}}, shifted[15:0]};
    assign rdata_word = {{(XLEN-32){sign_word}}, shifted[31:0]};

    always_comb begin
        if (lsu_op.is_byte) begin
            rdata = rdata_byte;
        end else if (lsu_op.is_half) begin
            rdata = rdata_half;
        end else if (lsu_op.is_word) begin
            rdata = rdata_word;
        end else begin
            rdata = dmem_rdata;             // Doubleword needs no shift
        end
    end

    // Size flags of a load are one hot or all clear
    always_comb begin
        if (lsu_op.load) begin
            assert ($onehot0({lsu_op.is_byte, lsu_op.is_half, lsu_op.is_word}));
        end
    end

endmodule

// ==== hdl/core_regfile.sv ====
// General purpose register file of the writeback top level with x0 fixed at zero
`timescale 1ns/1ps

module core_regfile
    import core_pkg::*;
(
    input  logic                  g_clk,       // Global clock
    input  logic                  g_resetn,    // Active low sync reset
    input  rd_write_t             wr,          // Write port from writeback
    input  logic [REG_ADDR_W-1:0] rs1_addr,    // Decode read address
    output logic [XLEN-1:0]       rs1_rdata    // Combinational read
);

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    logic [XLEN-1:0] regs [1:(2**REG_ADDR_W)-1];   // No entry for x0

    always_ff @(posedge g_clk) begin
        if (wr.wen && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.wdata;
        end
    end

    always_comb begin
        if (rs1_addr == '0) begin
            rs1_rdata = '0;
        end else begin
            rs1_rdata = regs[rs1_addr];
        end
    end

    // Writeback filters rd zero before it gets here
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        wr.wen |-> (wr.addr != '0));

endmodule

// ==== hdl/core_csrs.sv ====
// Reduced machine-mode CSR file that serves writeback CSR accesses and records traps and retires
`timescale 1ns/1ps

module core_csrs
    import core_pkg::*;
(
    input  logic     g_clk,       // Global clock
    input  logic     g_resetn,    // Active low sync reset
    input  csr_req_t req,         // Access from writeback
    output csr_rsp_t rsp,         // Old value and error
    input  trap_t    trap,        // Trap to capture
    input  logic     retire       // Non-trapping retire
);

    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;
    logic [XLEN-1:0] minstret;
    logic            sel_mscratch;
    logic            sel_mepc;
    logic            sel_mcause;
    logic            sel_mtval;
    logic            sel_minstret;
    logic            is_write;    // Any modifying op
    logic            csr_wen;
    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] new_val;

    // ------------------------------------------------------------------------
    // Decode and read
    // ------------------------------------------------------------------------
    assign sel_mscratch = (req.addr == CSR_MSCRATCH);
    assign sel_mepc     = (req.addr == CSR_MEPC);
    assign sel_mcause   = (req.addr == CSR_MCAUSE);
    assign sel_mtval    = (req.addr == CSR_MTVAL);
    assign sel_minstret = (req.addr == CSR_MINSTRET);
    assign is_write     = req.op.wr || req.op.set || req.op.clr;

    always_comb begin
        old_val = '0;
        if (sel_mscratch) old_val = mscratch;
        if (sel_mepc)     old_val = mepc;
        if (sel_mcause)   old_val = mcause;
        if (sel_mtval)    old_val = mtval;
        if (sel_minstret) old_val = minstret;   // Value before this retire
    end

    assign rsp.rdata = old_val;
    assign rsp.error = req.en && (!(sel_mscratch || sel_mepc || sel_mcause ||
                       sel_mtval || sel_minstret) || (sel_minstret && is_write));

    always_comb begin
        if (req.op.wr) begin
            new_val = req.wdata;
        end else if (req.op.set) begin
            new_val = old_val | req.wdata;
        end else begin
            new_val = old_val & ~req.wdata;     // Clear
        end
    end

    assign csr_wen = req.en && is_write && !rsp.error;

    // ------------------------------------------------------------------------
    // Update
    // ------------------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            minstret <= '0;
        end else begin
            if (csr_wen && sel_mscratch) mscratch <= new_val;
            if (trap.valid) begin               // Capture beats a CSR write
                mepc   <= trap.pc;
                mcause <= {{(XLEN-CAUSE_W){1'b0}}, trap.cause};
                mtval  <= trap.mtval;
            end else if (csr_wen) begin
                if (sel_mepc)   mepc   <= new_val;
                if (sel_mcause) mcause <= new_val;
                if (sel_mtval)  mtval  <= new_val;
            end
            if (retire) minstret <= minstret + 1'b1;
        end
    end

    // Writeback must never retire an instruction it also traps
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(retire && trap.valid));

endmodule

// ==== hdl/core_pipe_wb.sv ====
// Writeback stage under the top level that retires each finished packet to the GPRs and CSRs
`timescale 1ns/1ps

module core_pipe_wb
    import core_pkg::*;
(
    input  logic            g_clk,        // Global clock
    input  logic            g_resetn,     // Active low sync reset
    input  logic            s3_valid,     // New packet strobe
    input  wb_instr_t       s3_pkt,       // Packet from memory stage
    input  logic [XLEN-1:0] dmem_rdata,   // Valid the cycle after the strobe
    input  logic            dmem_err,     // Load bus error
    output rd_write_t       rd_write,     // GPR write port
    output csr_req_t        csr_req,      // CSR access
    input  csr_rsp_t        csr_rsp,      // Old value and access error
    output trap_t           trap,         // Trap raised by this packet
    output logic            retire,       // Retired without a trap
    output trace_t          trs           // Trace record
);

    logic            full;           // Stage holds a packet
    wb_instr_t       pkt;            // Stage register
    logic [XLEN-1:0] lsu_rdata;      // Aligned load data
    logic [XLEN-1:0] result;         // Selected GPR value
    logic            load_fault;
    logic            csr_fault;
    logic            any_trap;

    // ------------------------------------------------------------------------
    // Stage register
    // ------------------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            full <= 1'b0;
        end else begin
            full <= s3_valid;               // Packet leaves after one cycle
        end
    end

    always_ff @(posedge g_clk) begin
        if (s3_valid) begin
            pkt <= s3_pkt;
        end
    end

    // Low address bits give the byte lane of the load
    core_load_align u_core_load_align (
        .lsu_op     (pkt.lsu_op),
        .offset     (pkt.wdata[2:0]),
        .dmem_rdata (dmem_rdata),
        .rdata      (lsu_rdata)
    );

    // ------------------------------------------------------------------------
    // CSR request
    // ------------------------------------------------------------------------
    always_comb begin
        csr_req.en    = full && (pkt.csr_op != '0) && !pkt.trap;
        csr_req.op    = pkt.csr_op;
        csr_req.addr  = pkt.csr_addr;
        csr_req.wdata = pkt.wdata;          // CSR operand
    end

    // ------------------------------------------------------------------------
    // Traps
    // ------------------------------------------------------------------------
    assign load_fault = full && pkt.lsu_op.load && dmem_err;
    assign csr_fault  = csr_req.en && csr_rsp.error;
    assign any_trap   = full && (pkt.trap || load_fault || csr_fault);

    always_comb begin
        trap.valid = any_trap;
        trap.pc    = pkt.pc;
        trap.mtval = pkt.wdata;             // Upstream value or faulting address
        if (pkt.trap) begin                 // Upstream trap wins
            trap.cause = pkt.cause;
        end else if (load_fault) begin
            trap.cause = CAUSE_LOAD_FAULT;
        end else begin
            trap.cause = CAUSE_ILLEGAL;
            trap.mtval = {{(XLEN-32){1'b0}}, pkt.instr};
        end
    end

    // ------------------------------------------------------------------------
    // GPR writeback
    // ------------------------------------------------------------------------
    always_comb begin
        case (pkt.wb_op)
            WB_WDATA: result = pkt.wdata;
            WB_LSU:   result = lsu_rdata;
            WB_CSR:   result = csr_rsp.rdata;
            default:  result = '0;
        endcase
    end

    always_comb begin
        rd_write.wen   = full && !any_trap && (pkt.wb_op != WB_NONE) && (pkt.rd != '0);
        rd_write.addr  = pkt.rd;
        rd_write.wdata = result;
    end

    assign retire = full && !any_trap;      // Counts into minstret

    always_comb begin
        trs.valid = full;
        trs.pc    = pkt.pc;
        trs.instr = pkt.instr;
        trs.trap  = any_trap;
    end

    // A held packet carries at most one CSR access type
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        full |-> $onehot0(pkt.csr_op));

endmodule

// ==== hdl/core_wb_top.sv ====
// Writeback top level that joins the stage with the register file and the machine CSR file
`timescale 1ns/1ps

module core_wb_top
    import core_pkg::*;
(
    input  logic                  g_clk,        // Global clock
    input  logic                  g_resetn,     // Active low sync reset
    input  logic                  s3_valid,     // Packet strobe
    input  wb_instr_t             s3_pkt,       // Packet from memory stage
    input  logic [XLEN-1:0]       dmem_rdata,   // Load response data
    input  logic                  dmem_err,     // Load response error
    input  logic [REG_ADDR_W-1:0] rs1_addr,     // Decode read address
    output logic [XLEN-1:0]       rs1_rdata,
    output trace_t                trs,          // Instruction trace
    output trap_t                 trap          // Trap report
);

    rd_write_t rd_write;
    csr_req_t  csr_req;
    csr_rsp_t  csr_rsp;
    logic      retire;

    // ------------------------------------------------------------------------
    // Instances
    // ------------------------------------------------------------------------
    core_pipe_wb u_core_pipe_wb (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .s3_valid   (s3_valid),
        .s3_pkt     (s3_pkt),
        .dmem_rdata (dmem_rdata),
        .dmem_err   (dmem_err),
        .rd_write   (rd_write),
        .csr_req    (csr_req),
        .csr_rsp    (csr_rsp),
        .trap       (trap),
        .retire     (retire),
        .trs        (trs)
    );

    core_csrs u_core_csrs (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .req      (csr_req),
        .rsp      (csr_rsp),
        .trap     (trap),
        .retire   (retire)
    );

    core_regfile u_core_regfile (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .wr        (rd_write),
        .rs1_addr  (rs1_addr),
        .rs1_rdata (rs1_rdata)
    );

endmodule

// ==== verification/core_wb_tb.sv ====
// Testbench scoring random packets through the writeback top level against a reference model
`timescale 1ns/1ps

module core_wb_tb
    import core_pkg::*;
();

    localparam int N_ALU        = 40;
    localparam int N_LOAD       = 40;
    localparam int N_CSR_ROUNDS = 3;
    // Fill, ALU, loads, CSR rounds, minstret reads, four traps with three CSR reads each
    localparam int N_PKTS       = 32 + N_ALU + N_LOAD + 4 * N_CSR_ROUNDS + 2 + 4 * 4;
    localparam int MAX_CYCLES   = 2 * N_PKTS + 200;

    localparam csr_op_t OP_RD  = 4'b1000;
    localparam csr_op_t OP_WR  = 4'b0100;
    localparam csr_op_t OP_SET = 4'b0010;
    localparam csr_op_t OP_CLR = 4'b0001;
    localparam logic [CSR_ADDR_W-1:0] CSR_UNKNOWN = 12'h7C0;

    typedef struct packed {
        wb_instr_t       pkt;
        logic [XLEN-1:0] rdata;      // Load response for this packet
        logic            err;
    } sb_entry_t;

    logic                  g_clk;
    logic                  g_resetn;
    logic                  s3_valid;
    wb_instr_t             s3_pkt;
    logic [XLEN-1:0]       dmem_rdata;
    logic                  dmem_err;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [XLEN-1:0]       rs1_rdata;
    trace_t                trs;
    trap_t                 trap;

    sb_entry_t       sb_q [$];       // Packets waiting for their trace slot
    logic [XLEN-1:0] gpr [32];       // Shadow register file
    logic [XLEN-1:0] sh_mscratch;
    logic [XLEN-1:0] sh_mepc;
    logic [XLEN-1:0] sh_mcause;
    logic [XLEN-1:0] sh_mtval;
    logic [XLEN-1:0] sh_minstret;
    logic [31:0]     lfsr;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] pend_rdata;     // Response due in the next stage cycle
    logic            pend_err;
    logic            in_stage;
    int              errors;
    int              checks;

    core_wb_top u_core_wb_top (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .s3_valid   (s3_valid),
        .s3_pkt     (s3_pkt),
        .dmem_rdata (dmem_rdata),
        .dmem_err   (dmem_err),
        .rs1_addr   (rs1_addr),
        .rs1_rdata  (rs1_rdata),
        .trs        (trs),
        .trap       (trap)
    );

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;
    end

    // ------------------------------------------------------------------------
    // Random source and reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;    // x^32 + x^22 + x^2 + x + 1
        end
        return s >> 1;
    endfunction

    function automatic logic [XLEN-1:0] take_bits(input int n);
        logic [XLEN-1:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[XLEN-2:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    function automatic logic [XLEN-1:0] load_value(input lsu_op_t op, input logic [2:0] off,
                                                    input logic [XLEN-1:0] data);
        logic [XLEN-1:0] v;
        int              nbytes;
        nbytes = op.is_byte ? 1 : op.is_half ? 2 : op.is_word ? 4 : 8;
        if (nbytes == 8) begin
            return data;                       // Doubleword ignores the offset
        end
        v = '0;
        for (int i = 0; i < nbytes; i++) begin
            if (off + i < 8) begin
                v[8*i +: 8] = data[8*(off+i) +: 8];
            end
        end
        if (op.sext && v[8*nbytes-1]) begin
            for (int i = 8 * nbytes; i < XLEN; i++) begin
                v[i] = 1'b1;
            end
        end
        return v;
    endfunction

    // Predicts the trap and updates the shadow GPRs and CSRs for one packet
    function automatic trap_t model_wb(input wb_instr_t p, input logic [XLEN-1:0] rdata,
                                       input logic err);
        trap_t           t;
        logic            modify;
        logic            csr_acc;
        logic            csr_err;
        logic [XLEN-1:0] old_csr;
        logic [XLEN-1:0] new_csr;
        logic [XLEN-1:0] value;
        t       = '0;
        t.pc    = p.pc;
        modify  = p.csr_op.wr || p.csr_op.set || p.csr_op.clr;
        csr_acc = (p.csr_op != '0) && !p.trap;
        csr_err = csr_acc && (!(p.csr_addr inside {CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE,
                  CSR_MTVAL, CSR_MINSTRET}) || (p.csr_addr == CSR_MINSTRET && modify));
        if (p.trap) begin
            t.valid = 1'b1;
            t.cause = p.cause;
            t.mtval = p.wdata;
        end else if (p.lsu_op.load && err) begin
            t.valid = 1'b1;
            t.cause = CAUSE_LOAD_FAULT;
            t.mtval = p.wdata;                 // Faulting address
        end else if (csr_err) begin
            t.valid = 1'b1;
            t.cause = CAUSE_ILLEGAL;
            t.mtval = 64'(p.instr);
        end
        case (p.csr_addr)
            CSR_MSCRATCH: old_csr = sh_mscratch;
            CSR_MEPC:     old_csr = sh_mepc;
            CSR_MCAUSE:   old_csr = sh_mcause;
            CSR_MTVAL:    old_csr = sh_mtval;
            CSR_MINSTRET: old_csr = sh_minstret;
            default:      old_csr = '0;
        endcase
        if (p.csr_op.wr) begin
            new_csr = p.wdata;
        end else if (p.csr_op.set) begin
            new_csr = old_csr | p.wdata;
        end else if (p.csr_op.clr) begin
            new_csr = old_csr & ~p.wdata;
        end else begin
            new_csr = old_csr;
        end
        if (csr_acc && !csr_err) begin
            case (p.csr_addr)
                CSR_MSCRATCH: sh_mscratch = new_csr;
                CSR_MEPC:     sh_mepc     = new_csr;
                CSR_MCAUSE:   sh_mcause   = new_csr;
                CSR_MTVAL:    sh_mtval    = new_csr;
                default:      ;
            endcase
        end
        if (t.valid) begin                     // Capture wins over the CSR write
            sh_mepc   = t.pc;
            sh_mcause = 64'(t.cause);
            sh_mtval  = t.mtval;
        end else begin
            sh_minstret = sh_minstret + 64'd1;
        end
        case (p.wb_op)
            WB_WDATA: value = p.wdata;
            WB_LSU:   value = load_value(p.lsu_op, p.wdata[2:0], rdata);
            WB_CSR:   value = old_csr;
            default:  value = '0;
        endcase
        if (!t.valid && p.wb_op != WB_NONE && p.rd != '0) begin
            gpr[p.rd] = value;
        end
        return t;
    endfunction

    task automatic compare_value(input string name, input logic [XLEN-1:0] expected,
                                 input logic [XLEN-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------------------
    // Scoreboard with one trace slot per strobe
    // ------------------------------------------------------------------------
    always @(posedge g_clk) begin : score
        sb_entry_t e;
        trap_t     exp_trap;
        if (!g_resetn) begin
            in_stage = 1'b0;
        end else begin
            if (in_stage) begin
                e        = sb_q.pop_front();
                exp_trap = model_wb(e.pkt, e.rdata, e.err);
                compare_value("trs.valid", 64'd1, 64'(trs.valid));
                compare_value("trs.pc", e.pkt.pc, trs.pc);
                compare_value("trs.instr", 64'(e.pkt.instr), 64'(trs.instr));
                compare_value("trs.trap", 64'(exp_trap.valid), 64'(trs.trap));
                compare_value("trap.valid", 64'(exp_trap.valid), 64'(trap.valid));
                if (exp_trap.valid) begin
                    compare_value("trap.cause", 64'(exp_trap.cause), 64'(trap.cause));
                    compare_value("trap.mtval", exp_trap.mtval, trap.mtval);
                    compare_value("trap.pc", exp_trap.pc, trap.pc);
                end
            end else begin
                compare_value("trs.valid", '0, 64'(trs.valid));   // Idle slot
                compare_value("trap.valid", '0, 64'(trap.valid));
            end
            in_stage = s3_valid;
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    function automatic wb_instr_t base_pkt();
        wb_instr_t p;
        p       = '0;
        p.pc    = next_pc;
        p.n_pc  = next_pc + 64'd4;
        p.instr = 32'(take_bits(32));
        next_pc = next_pc + 64'd4;
        return p;
    endfunction

    function automatic wb_instr_t alu_pkt();
        wb_instr_t p;
        p       = base_pkt();
        p.rd    = 5'(take_bits(5));
        p.wdata = take_bits(64);
        p.wb_op = WB_WDATA;
        return p;
    endfunction

    function automatic wb_instr_t csr_pkt(input csr_op_t op, input logic [CSR_ADDR_W-1:0] addr,
                                          input logic [XLEN-1:0] operand,
                                          input logic [REG_ADDR_W-1:0] rd);
        wb_instr_t p;
        p          = base_pkt();
        p.csr_op   = op;
        p.csr_addr = addr;
        p.wdata    = operand;
        p.rd       = rd;
        p.wb_op    = WB_CSR;
        return p;
    endfunction

    // The previous packet's response goes out with this strobe
    task automatic send(input wb_instr_t p, input logic [XLEN-1:0] rdata, input logic err);
        sb_entry_t e;
        @(negedge g_clk);
        dmem_rdata = pend_rdata;
        dmem_err   = pend_err;
        s3_valid   = 1'b1;
        s3_pkt     = p;
        pend_rdata = rdata;
        pend_err   = err;
        e.pkt      = p;
        e.rdata    = rdata;
        e.err      = err;
        sb_q.push_back(e);
    endtask

    task automatic idle_cycle();
        @(negedge g_clk);
        dmem_rdata = pend_rdata;
        dmem_err   = pend_err;
        s3_valid   = 1'b0;
        pend_rdata = '0;
        pend_err   = 1'b0;
    endtask

    task automatic send_load(input logic err);
        wb_instr_t       p;
        logic [XLEN-1:0] addr;
        logic [1:0]      size;
        logic [2:0]      off;
        p                = base_pkt();
        size             = 2'(take_bits(2));
        off              = 3'(take_bits(3));
        off              = off & ~((3'd1 << size) - 3'd1);   // Natural alignment
        addr             = take_bits(64);
        p.lsu_op.load    = 1'b1;
        p.lsu_op.is_byte = (size == 2'd0);
        p.lsu_op.is_half = (size == 2'd1);
        p.lsu_op.is_word = (size == 2'd2);
        p.lsu_op.sext    = 1'(take_bits(1));
        p.wdata          = {addr[XLEN-1:3], off};
        p.rd             = 5'(take_bits(5));
        p.wb_op          = WB_LSU;
        send(p, take_bits(64), err);
    endtask

    task automatic read_gpr(input int addr);
        idle_cycle();
        rs1_addr = 5'(addr);
        @(posedge g_clk);
        compare_value($sformatf("rs1_rdata x%0d", addr), gpr[addr], rs1_rdata);
    endtask

    task automatic verify_gprs();
        idle_cycle();
        idle_cycle();
        for (int r = 0; r < 32; r++) begin
            read_gpr(r);
        end
    endtask

    // Copies the captured trap CSRs into x14..x16 and reads them back
    task automatic read_trap_state();
        send(csr_pkt(OP_RD, CSR_MEPC, '0, 5'd14), '0, 1'b0);
        send(csr_pkt(OP_RD, CSR_MCAUSE, '0, 5'd15), '0, 1'b0);
        send(csr_pkt(OP_RD, CSR_MTVAL, '0, 5'd16), '0, 1'b0);
        idle_cycle();
        idle_cycle();
        for (int r = 14; r <= 16; r++) begin
            read_gpr(r);
        end
    endtask

    initial begin : stimulus
        wb_instr_t p;
        g_resetn    = 1'b0;
        s3_valid    = 1'b0;
        s3_pkt      = '0;
        dmem_rdata  = '0;
        dmem_err    = 1'b0;
        rs1_addr    = '0;
        lfsr        = 32'd25;
        next_pc     = 64'h8000_0000;
        pend_rdata  = '0;
        pend_err    = 1'b0;
        errors      = 0;
        checks      = 0;
        sh_mscratch = '0;
        sh_mepc     = '0;
        sh_mcause   = '0;
        sh_mtval    = '0;
        sh_minstret = '0;
        for (int r = 0; r < 32; r++) begin
            gpr[r] = '0;
        end
        repeat (8) @(negedge g_clk);
        g_resetn = 1'b1;

        for (int r = 0; r < 32; r++) begin      // Writes every register including x0
            p    = alu_pkt();
            p.rd = 5'(r);
            send(p, '0, 1'b0);
        end
        for (int i = 0; i < N_ALU; i++) begin
            send(alu_pkt(), '0, 1'b0);
        end
        verify_gprs();

        for (int i = 0; i < N_LOAD; i++) begin
            send_load(1'b0);
        end
        verify_gprs();

        for (int i = 0; i < N_CSR_ROUNDS; i++) begin
            send(csr_pkt(OP_WR, CSR_MSCRATCH, take_bits(64), 5'd5), '0, 1'b0);
            send(csr_pkt(OP_SET, CSR_MSCRATCH, take_bits(64), 5'd6), '0, 1'b0);
            send(csr_pkt(OP_CLR, CSR_MSCRATCH, take_bits(64), 5'd7), '0, 1'b0);
            send(csr_pkt(OP_RD, CSR_MSCRATCH, '0, 5'd8), '0, 1'b0);
        end
        send(csr_pkt(OP_RD, CSR_MINSTRET, '0, 5'd9), '0, 1'b0);
        verify_gprs();

        p       = alu_pkt();                   // Upstream trap flag
        p.trap  = 1'b1;
        p.cause = 6'(take_bits(6));
        send(p, '0, 1'b0);
        read_trap_state();
        send_load(1'b1);
        read_trap_state();
        send(csr_pkt(OP_RD, CSR_UNKNOWN, '0, 5'd12), '0, 1'b0);
        read_trap_state();
        send(csr_pkt(OP_WR, CSR_MINSTRET, take_bits(64), 5'd13), '0, 1'b0);
        read_trap_state();
        send(csr_pkt(OP_RD, CSR_MINSTRET, '0, 5'd9), '0, 1'b0);
        verify_gprs();

        idle_cycle();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge g_clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== core_wb_top.f ====
hdl/core_pkg.sv
hdl/core_load_align.sv
hdl/core_regfile.sv
hdl/core_csrs.sv
hdl/core_pipe_wb.sv
hdl/core_wb_top.sv
verification/core_wb_tb.sv

// ==== Makefile ====
TOP := core_wb_tb

.PHONY: all build run lint clean

all: run

build: obj_dir/V$(TOP)

obj_dir/V$(TOP): core_wb_top.f hdl/*.sv verification/*.sv
	verilator --binary --timing --assert -Wno-fatal -f core_wb_top.f \
		--top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -qx "=== PASS ===" sim.log; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing -f core_wb_top.f --top-module core_wb_top

clean:
	rm -rf obj_dir sim.log
